// ==== Bender.yml ====
package:
  name: ipod_speed

sources:
  - files:
      - hw/speed_pkg.sv
      - hw/display_pkg.sv
      - hw/key_sync_stage.sv
      - hw/key_repeat_limiter.sv
      - hw/speed_offset_reg.sv
      - hw/sample_rate_divider.sv
      - hw/hex_display.sv
      - hw/ipod_speed_top.sv
  - target: simulation
    files:
      - dv/ipod_speed_sva.sv
      - dv/tb_ipod_speed.sv

// ==== all.f ====
hw/speed_pkg.sv
hw/display_pkg.sv
hw/key_sync_stage.sv
hw/key_repeat_limiter.sv
hw/speed_offset_reg.sv
hw/sample_rate_divider.sv
hw/hex_display.sv
hw/ipod_speed_top.sv
dv/ipod_speed_sva.sv
dv/tb_ipod_speed.sv

// ==== dv/ipod_speed_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

module ipod_speed_sva #(
  parameter int WINDOW = 1000
) (
  input wire logic                  CLK_50M,
  input wire logic                  arst_n,
  input wire logic                  sample_tick,
  input wire speed_pkg::speed_cmd_t cmd,
  input wire speed_pkg::offset_t    offset
);

  logic step_cmd;
  logic no_cmd_yet;
  int   since_step;

  assign step_cmd = cmd.valid && (cmd.op != speed_pkg::OP_RESET);

  // Cycles since last up/down command, saturates at one window
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      since_step <= WINDOW;
    else if (step_cmd)
      since_step <= 1;
    else if (since_step < WINDOW)
      since_step <= since_step + 1;
  end

  // High from reset until the first command of any kind
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      no_cmd_yet <= 1'b1;
    else if (cmd.valid)
      no_cmd_yet <= 1'b0;
  end

  a_tick_single: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    sample_tick |=> !sample_tick)
    else $error("sample_tick high on two cycles in a row");

  a_one_step_per_window: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    step_cmd |-> since_step >= WINDOW)
    else $error("up/down command repeated inside one repeat window");

  a_offset_after_reset: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    no_cmd_yet |-> offset == '0)
    else $error("speed offset moved from zero before any command");

endmodule

bind ipod_speed_top ipod_speed_sva #(
  .WINDOW (TICK_DIV * speed_pkg::REPEAT_TICKS)
) u_sva (
  .CLK_50M     (CLK_50M),
  .arst_n      (arst_n),
  .sample_tick (sample_tick),
  .cmd         (cmd),
  .offset      (offset)
);

`default_nettype wire

// ==== dv/tb_ipod_speed.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_ipod_speed;

  localparam int TICK_DIV = 10;
  localparam int REFRESH  = 200;
  localparam int WINDOW   = TICK_DIV * speed_pkg::REPEAT_TICKS;
  localparam int BASE     = speed_pkg::DEFAULT_SAMPLE_COUNT;
  localparam int STEP     = speed_pkg::SPEED_STEP;
  // Five period checks of about 26 windows each, plus settle time
  localparam int MARGIN_WINDOWS = 160;

  // Active-low a..g patterns for digits 0 to F
  localparam display_pkg::seg_t SEG_TABLE [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
  };

  typedef enum {W_OFF, W_RISE, W_FALL, W_HOLD} watch_e;

  logic                   CLK_50M;
  logic                   arst_n;
  logic [2:0]             key_n;
  logic                   sample_tick;
  display_pkg::hex_bank_t hex;

  int     seed = 14;
  int     err_count = 0;
  int     cycle_cnt = 0;
  int     last_tick_cyc = 0;
  int     tick_cnt = 0;
  int     last_period = 0;
  int     disp_count = -1;
  int     prev_disp = -1;
  // Count the display should reach next in a watched test
  int     model_disp = BASE;
  int     up_w;
  int     down_w;
  int     cancel_w;
  bit     plan_ready = 1'b0;
  watch_e watch = W_OFF;
  string  test_name = "reset_state";

  ipod_speed_top #(
    .TICK_DIV    (TICK_DIV),
    .REFRESH_DIV (REFRESH)
  ) dut (
    .CLK_50M     (CLK_50M),
    .arst_n      (arst_n),
    .key_n       (key_n),
    .sample_tick (sample_tick),
    .hex         (hex)
  );

  // ====================
  // Reference and compare
  // ====================

  function automatic display_pkg::hex_bank_t expected_hex(input int value);
    display_pkg::hex_bank_t bank;
    for (int d = 0; d < display_pkg::HEX_DIGITS; d++)
      bank[d] = SEG_TABLE[(value >> (4 * d)) & 15];
    return bank;
  endfunction

  // Digits back into a number, -1 for an unknown pattern
  function automatic int decode_hex(input display_pkg::hex_bank_t bank);
    int value;
    int nib;
    value = 0;
    for (int d = display_pkg::HEX_DIGITS - 1; d >= 0; d--)
    begin
      nib = -1;
      for (int n = 0; n < 16; n++)
        if (SEG_TABLE[n] === bank[d])
          nib = n;
      if (nib < 0)
        return -1;
      value = (value << 4) | nib;
    end
    return value;
  endfunction

  task automatic check_hex(input string name, input display_pkg::hex_bank_t exp,
                           input display_pkg::hex_bank_t act);
    if (act !== exp)
    begin
      err_count++;
      $display("ERR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input speed_pkg::count_t exp,
                             input speed_pkg::count_t act);
    if (act !== exp)
    begin
      err_count++;
      $display("ERR %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  // Display decode, trend checks and strobe timing
  always @(negedge CLK_50M)
  begin
    if (arst_n)
    begin
      cycle_cnt++;
      if (sample_tick)
      begin
        last_period = cycle_cnt - last_tick_cyc;
        last_tick_cyc = cycle_cnt;
        tick_cnt++;
      end
      disp_count = decode_hex(hex);
      if (disp_count != prev_disp)
      begin
        if (disp_count < 0)
        begin
          err_count++;
          $display("%s: display shows a pattern that is no hex digit", test_name);
        end
        else
        begin
          case (watch)
            W_RISE:
            begin
              model_disp += STEP;
              check_hex(test_name, expected_hex(model_disp), hex);
            end
            W_FALL:
            begin
              model_disp -= STEP;
              check_hex(test_name, expected_hex(model_disp), hex);
            end
            W_HOLD: check_hex(test_name, expected_hex(model_disp), hex);
            default: ;
          endcase
        end
        prev_disp = disp_count;
      end
    end
  end

  // ====================
  // Stimulus
  // ====================

  task automatic press_keys(input logic [2:0] pattern_n, input int cycles);
    @(posedge CLK_50M);
    key_n <= pattern_n;
    repeat (cycles) @(posedge CLK_50M);
    key_n <= 3'b111;
  endtask

  task automatic wait_strobes(input int n);
    int target;
    target = tick_cnt + n;
    wait (tick_cnt >= target);
  endtask

  // Settled display, then the period that the new count sets
  task automatic check_speed(input int exp_count);
    repeat (REFRESH + 20) @(posedge CLK_50M);
    watch = W_OFF;
    @(negedge CLK_50M);
    check_hex(test_name, expected_hex(exp_count), hex);
    model_disp = exp_count;
    wait_strobes(2);
    check_count({test_name, "_period"}, speed_pkg::count_t'(exp_count + 1),
                speed_pkg::count_t'(last_period));
  endtask

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  initial
  begin
    arst_n = 1'b0;
    key_n  = 3'b111;
    up_w     = 1 + {$random(seed)} % 5;
    down_w   = up_w + 1 + {$random(seed)} % 5;
    cancel_w = 1 + {$random(seed)} % 5;
    plan_ready = 1'b1;
    repeat (8) @(posedge CLK_50M);
    arst_n <= 1'b1;

    check_speed(BASE);

    test_name = "speed_up";
    watch = W_RISE;
    press_keys(3'b110, up_w * WINDOW);
    check_speed(BASE + up_w * STEP);

    // Held longer than up, so the offset goes negative
    test_name = "speed_down";
    watch = W_FALL;
    press_keys(3'b101, down_w * WINDOW);
    check_speed(BASE + (up_w - down_w) * STEP);

    test_name = "cancel";
    watch = W_HOLD;
    press_keys(3'b100, cancel_w * WINDOW);
    check_speed(BASE + (up_w - down_w) * STEP);

    test_name = "speed_reset";
    press_keys(3'b011, 5);
    check_speed(BASE);

    $display("Checks done with %0d errors", err_count);
    if (err_count == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  // Watchdog sized from the drawn hold lengths
  initial
  begin
    wait (plan_ready);
    repeat ((up_w + down_w + cancel_w + MARGIN_WINDOWS) * WINDOW) @(posedge CLK_50M);
    $display("Timeout: the tests did not finish in the expected number of cycles");
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/display_pkg.sv ====
`default_nettype none

package display_pkg;

  // ====================
  // Display constants
  // ====================

  // Six digits cover a 24-bit hex value
  localparam int HEX_DIGITS = 6;

  // Cycles between display refreshes, 2 Hz at 50 MHz
  localparam int REFRESH_DIV_DEFAULT = 25000000;

  // ====================
  // Types
  // ====================

  // Active low, bit 0 is segment a up to bit 6 for segment g
  typedef logic [6:0] seg_t;

  // Element 0 drives the rightmost digit
  typedef seg_t [HEX_DIGITS-1:0] hex_bank_t;

endpackage

`default_nettype wire

// ==== hw/hex_display.sv ====
`timescale 1ns/10ps
`default_nettype none

module hex_display #(
  parameter int REFRESH_DIV = display_pkg::REFRESH_DIV_DEFAULT
) (
  input  wire logic                   CLK_50M,
  input  wire logic                   arst_n,
  input  wire speed_pkg::count_t      count,
  output      display_pkg::hex_bank_t hex
);

  localparam int LATCH_W = 4 * display_pkg::HEX_DIGITS;
  localparam int REF_W   = $clog2(REFRESH_DIV + 1);

  logic [REF_W-1:0]   ref_cnt;
  logic [LATCH_W-1:0] shown;

  // Active-low pattern for one hex digit
  function automatic display_pkg::seg_t nibble_to_seg(input logic [3:0] nib);
    display_pkg::seg_t seg;
    case (nib)
      4'h0: seg = 7'b1000000;
      4'h1: seg = 7'b1111001;
      4'h2: seg = 7'b0100100;
      4'h3: seg = 7'b0110000;
      4'h4: seg = 7'b0011001;
      4'h5: seg = 7'b0010010;
      4'h6: seg = 7'b0000010;
      4'h7: seg = 7'b1111000;
      4'h8: seg = 7'b0000000;
      4'h9: seg = 7'b0010000;
      4'hA: seg = 7'b0001000;
      4'hB: seg = 7'b0000011;
      4'hC: seg = 7'b1000110;
      4'hD: seg = 7'b0100001;
      4'hE: seg = 7'b0000110;
      default: seg = 7'b0001110;
    endcase
    return seg;
  endfunction

  // ====================
  // Refresh latch
  // ====================

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ref_cnt <= '0;
      shown   <= LATCH_W'(speed_pkg::DEFAULT_SAMPLE_COUNT);
    end
    else if (ref_cnt == REF_W'(REFRESH_DIV - 1))
    begin
      ref_cnt <= '0;
      shown   <= LATCH_W'(count);
    end
    else
    begin
      ref_cnt <= ref_cnt + 1'b1;
    end
  end

  // ====================
  // Digit decoders
  // ====================

  for (genvar d = 0; d < display_pkg::HEX_DIGITS; d++)
  begin : g_digit
    assign hex[d] = nibble_to_seg(shown[4*d +: 4]);
  end

endmodule

`default_nettype wire

// ==== hw/ipod_speed_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module ipod_speed_top #(
  parameter int TICK_DIV    = speed_pkg::TICK_DIV_DEFAULT,
  parameter int REFRESH_DIV = display_pkg::REFRESH_DIV_DEFAULT
) (
  input  wire logic                   CLK_50M,
  input  wire logic                   arst_n,
  input  wire logic [2:0]             key_n,
  output      logic                   sample_tick,
  output      display_pkg::hex_bank_t hex
);

  speed_pkg::speed_keys_t keys;
  speed_pkg::speed_cmd_t  cmd;
  speed_pkg::offset_t     offset;
  speed_pkg::count_t      count;

  // ====================
  // Key path
  // ====================

  key_sync_stage u_key_sync (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .key_n   (key_n),
    .keys    (keys)
  );

  key_repeat_limiter #(
    .TICK_DIV (TICK_DIV)
  ) u_repeat (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .keys    (keys),
    .cmd     (cmd)
  );

  // ====================
  // Rate and display
  // ====================

  speed_offset_reg u_offset (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .cmd     (cmd),
    .offset  (offset)
  );

  sample_rate_divider u_divider (
    .CLK_50M     (CLK_50M),
    .arst_n      (arst_n),
    .offset      (offset),
    .count       (count),
    .sample_tick (sample_tick)
  );

  hex_display #(
    .REFRESH_DIV (REFRESH_DIV)
  ) u_display (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .count   (count),
    .hex     (hex)
  );

endmodule

`default_nettype wire

// ==== hw/key_repeat_limiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module key_repeat_limiter #(
  parameter int TICK_DIV = speed_pkg::TICK_DIV_DEFAULT
) (
  input  wire logic                   CLK_50M,
  input  wire logic                   arst_n,
  input  wire speed_pkg::speed_keys_t keys,
  output      speed_pkg::speed_cmd_t  cmd
);

  localparam int PRE_W = $clog2(TICK_DIV + 1);
  localparam int WIN_W = $clog2(speed_pkg::REPEAT_TICKS + 1);

  logic [PRE_W-1:0]      pre_cnt;
  logic [WIN_W-1:0]      win_cnt;
  logic                  ms_tick;
  logic                  win_end;
  speed_pkg::speed_cmd_t cmd_q;

  // ====================
  // Millisecond tick
  // ====================

  assign ms_tick = (pre_cnt == PRE_W'(TICK_DIV - 1));
  assign win_end = ms_tick && (win_cnt == WIN_W'(speed_pkg::REPEAT_TICKS - 1));

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pre_cnt <= '0;
      win_cnt <= '0;
    end
    else
    begin
      if (ms_tick)
      begin
        pre_cnt <= '0;
        // Window counter only moves on ticks
        if (win_end)
          win_cnt <= '0;
        else
          win_cnt <= win_cnt + 1'b1;
      end
      else
      begin
        pre_cnt <= pre_cnt + 1'b1;
      end
    end
  end

  // ====================
  // Command strobe
  // ====================

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      cmd_q <= '{valid: 1'b0, op: speed_pkg::OP_UP};
    end
    else
    begin
      cmd_q.valid <= 1'b0;
      if (keys.rst)
      begin
        // Reset key wins over anything the window would send
        cmd_q.valid <= 1'b1;
        cmd_q.op    <= speed_pkg::OP_RESET;
      end
      else if (win_end && (keys.up ^ keys.down))
      begin
        cmd_q.valid <= 1'b1;
        cmd_q.op    <= keys.up ? speed_pkg::OP_UP : speed_pkg::OP_DOWN;
      end
    end
  end

  assign cmd = cmd_q;

endmodule

`default_nettype wire

// ==== hw/key_sync_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module key_sync_stage (
  input  wire logic                  CLK_50M,
  input  wire logic                  arst_n,
  input  wire logic [2:0]            key_n,
  output      speed_pkg::speed_keys_t keys
);

  // First stage may go metastable, second one is clean
  logic [2:0] key_meta;
  logic [2:0] key_sync;

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      // Keys idle high when released
      key_meta <= 3'b111;
      key_sync <= 3'b111;
    end
    else
    begin
      key_meta <= key_n;
      key_sync <= key_meta;
    end
  end

  // Flip to active-high named levels
  assign keys.up   = ~key_sync[0];
  assign keys.down = ~key_sync[1];
  assign keys.rst  = ~key_sync[2];

endmodule

`default_nettype wire

// ==== hw/sample_rate_divider.sv ====
`timescale 1ns/10ps
`default_nettype none

module sample_rate_divider (
  input  wire logic               CLK_50M,
  input  wire logic               arst_n,
  input  wire speed_pkg::offset_t offset,
  output      speed_pkg::count_t  count,
  output      logic               sample_tick
);

  localparam speed_pkg::count_t BASE = speed_pkg::count_t'(speed_pkg::DEFAULT_SAMPLE_COUNT);

  speed_pkg::count_t count_q;
  speed_pkg::count_t div_cnt;

  // ====================
  // Divider count
  // ====================

  // Same width, so two's complement add handles negative offsets
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      count_q <= BASE;
    else
      count_q <= BASE + speed_pkg::count_t'(offset);
  end

  // ====================
  // Strobe generator
  // ====================

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      div_cnt     <= BASE;
      sample_tick <= 1'b0;
    end
    else if (div_cnt == '0)
    begin
      // Reload here so a new rate starts on a clean period
      div_cnt     <= count_q;
      sample_tick <= 1'b1;
    end
    else
    begin
      div_cnt     <= div_cnt - 1'b1;
      sample_tick <= 1'b0;
    end
  end

  assign count = count_q;

endmodule

`default_nettype wire

// ==== hw/speed_offset_reg.sv ====
`timescale 1ns/10ps
`default_nettype none

module speed_offset_reg (
  input  wire logic                  CLK_50M,
  input  wire logic                  arst_n,
  input  wire speed_pkg::speed_cmd_t cmd,
  output      speed_pkg::offset_t    offset
);

  localparam speed_pkg::offset_t STEP = speed_pkg::offset_t'(speed_pkg::SPEED_STEP);

  speed_pkg::offset_t offset_q;

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      offset_q <= '0;
    end
    else if (cmd.valid)
    begin
      case (cmd.op)
        speed_pkg::OP_UP:
        begin
          offset_q <= offset_q + STEP;
        end
        speed_pkg::OP_DOWN:
        begin
          offset_q <= offset_q - STEP;
        end
        speed_pkg::OP_RESET:
        begin
          offset_q <= '0;
        end
        default:
        begin
          // Unused encoding, keep current speed
          offset_q <= offset_q;
        end
      endcase
    end
  end

  assign offset = offset_q;

endmodule

`default_nettype wire

// ==== hw/speed_pkg.sv ====
`default_nettype none

package speed_pkg;

  // ====================
  // Speed path constants
  // ====================

  // Offset change per up/down command
  localparam int SPEED_STEP = 100;

  // Sample divider count at zero offset, 50 MHz / 12500 = 4 kHz strobe
  localparam int DEFAULT_SAMPLE_COUNT = 12499;

  // Millisecond ticks per key repeat window
  localparam int REPEAT_TICKS = 100;

  // CLK_50M cycles per millisecond tick
  localparam int TICK_DIV_DEFAULT = 50000;

  // ====================
  // Types
  // ====================

  // Active-high key levels after sync
  typedef struct packed {
    logic up;
    logic down;
    logic rst;
  } speed_keys_t;

  typedef enum logic [1:0] {
    OP_UP    = 2'd0,
    OP_DOWN  = 2'd1,
    OP_RESET = 2'd2
  } speed_op_e;

  // One-cycle command strobe with its opcode
  typedef struct packed {
    logic      valid;
    speed_op_e op;
  } speed_cmd_t;

  typedef logic signed [15:0] offset_t;
  typedef logic [15:0] count_t;

endpackage

`default_nettype wire
